/* files.f */
logic/line_format_pkg.sv
logic/response_pkg.sv
logic/response_capture.sv
logic/line_buffer.sv
logic/word_sequencer.sv
logic/cacheline_stream_top.sv
sim/cacheline_stream_checker.sv
sim/cacheline_stream_tb.sv

/* logic/cacheline_stream_top.sv */
// Cache-line unpacking path, capture then line buffer then word sequencer
module cacheline_stream_top
	import line_format_pkg::*;
	import response_pkg::*;
#(
	parameter bit SWAP_BYTES = 1'b1
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  logic                   start_shift,
	input  struct_id_t             struct_sel,

	input  logic                   resp_0_valid,
	input  half_line_u             resp_0_data,
	input  struct_id_t             resp_0_struct,
	input  logic [OFFSET_BITS-1:0] resp_0_offset,
	input  logic [COUNT_BITS-1:0]  resp_0_count,

	input  logic                   resp_1_valid,
	input  half_line_u             resp_1_data,
	input  struct_id_t             resp_1_struct,
	input  logic [OFFSET_BITS-1:0] resp_1_offset,
	input  logic [COUNT_BITS-1:0]  resp_1_count,

	output logic [WORD_BITS-1:0]   word,
	output logic                   valid,
	output logic                   pending
);

	// --------------------------------------------------
	// Stage links
	// --------------------------------------------------
	logic                       wr_en;
	logic                       wr_half;
	half_line_u                 wr_data;
	logic                       load;
	logic [OFFSET_BITS-1:0]     load_offset;
	logic [COUNT_BITS-1:0]      load_count;
	logic [WORD_INDEX_BITS-1:0] rd_index;
	logic [WORD_BITS-1:0]       rd_word;

	response_capture u_capture (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.struct_sel    (struct_sel),
		.resp_0_valid  (resp_0_valid),
		.resp_0_data   (resp_0_data),
		.resp_0_struct (resp_0_struct),
		.resp_0_offset (resp_0_offset),
		.resp_0_count  (resp_0_count),
		.resp_1_valid  (resp_1_valid),
		.resp_1_data   (resp_1_data),
		.resp_1_struct (resp_1_struct),
		.resp_1_offset (resp_1_offset),
		.resp_1_count  (resp_1_count),
		.wr_en         (wr_en),
		.wr_half       (wr_half),
		.wr_data       (wr_data),
		.load          (load),
		.load_offset   (load_offset),
		.load_count    (load_count)
	);

	line_buffer u_buffer (
		.clock    (clock),
		.wr_en    (wr_en),
		.wr_half  (wr_half),
		.wr_data  (wr_data),
		.rd_index (rd_index),
		.rd_word  (rd_word)
	);

	word_sequencer #(
		.SWAP_BYTES (SWAP_BYTES)
	) u_sequencer (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.start_shift (start_shift),
		.load        (load),
		.load_offset (load_offset),
		.load_count  (load_count),
		.rd_word     (rd_word),
		.rd_index    (rd_index),
		.word        (word),
		.valid       (valid),
		.pending     (pending)
	);

endmodule

/* logic/line_buffer.sv */
// Two-half line store, written a half at a time, read one word per cycle
module line_buffer
	import line_format_pkg::*;
(
	input  logic                       clock,
	input  logic                       wr_en,
	input  logic                       wr_half,
	input  half_line_u                 wr_data,
	input  logic [WORD_INDEX_BITS-1:0] rd_index,
	output logic [WORD_BITS-1:0]       rd_word
);

	localparam int HALVES = LINE_BITS / HALF_BITS;

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	half_line_u mem [HALVES];

	logic                              rd_half;
	logic [WORD_INDEX_BITS-2:0]        rd_sub;

	// Upper index bit picks the half, the rest picks the word
	assign rd_half = rd_index[WORD_INDEX_BITS-1];
	assign rd_sub  = rd_index[WORD_INDEX_BITS-2:0];

	// Half line write
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_half] <= wr_data;
		end
	end

	// --------------------------------------------------
	// Registered word read
	// --------------------------------------------------
	// Data shows up one cycle after the index
	always_ff @(posedge clock) begin
		rd_word <= mem[rd_half].words[rd_sub];
	end

endmodule

/* logic/line_format_pkg.sv */
// Cache line, half line and word formats shared by the unpacking path
package line_format_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------
	localparam int LINE_BITS       = 256;
	localparam int HALF_BITS       = LINE_BITS / 2;
	localparam int WORD_BITS       = 32;
	localparam int WORDS_PER_HALF  = HALF_BITS / WORD_BITS;
	localparam int WORDS_PER_LINE  = LINE_BITS / WORD_BITS;
	localparam int WORD_INDEX_BITS = $clog2(WORDS_PER_LINE);

	// --------------------------------------------------
	// Half line, seen as one vector or as four words
	// --------------------------------------------------
	// Word 0 sits in the least significant bits
	typedef union packed {
		logic [HALF_BITS-1:0]                      raw;
		logic [WORDS_PER_HALF-1:0][WORD_BITS-1:0]  words;
	} half_line_u;

	// Reverse the byte order inside one word
	function automatic logic [WORD_BITS-1:0] swap_word_bytes(
		input logic [WORD_BITS-1:0] w
	);
		logic [WORD_BITS-1:0] r;
		r = '0;
		for (int i = 0; i < WORD_BITS / 8; i++) begin
			r[8*i +: 8] = w[WORD_BITS-8-8*i +: 8];
		end
		return r;
	endfunction

endpackage

/* logic/response_capture.sv */
// Response capture stage, latches one response port and decides acceptance
module response_capture
	import line_format_pkg::*;
	import response_pkg::*;
(
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   enabled,
	input  struct_id_t             struct_sel,

	input  logic                   resp_0_valid,
	input  half_line_u             resp_0_data,
	input  struct_id_t             resp_0_struct,
	input  logic [OFFSET_BITS-1:0] resp_0_offset,
	input  logic [COUNT_BITS-1:0]  resp_0_count,

	input  logic                   resp_1_valid,
	input  half_line_u             resp_1_data,
	input  struct_id_t             resp_1_struct,
	input  logic [OFFSET_BITS-1:0] resp_1_offset,
	input  logic [COUNT_BITS-1:0]  resp_1_count,

	output logic                   wr_en,
	output logic                   wr_half,
	output half_line_u             wr_data,
	output logic                   load,
	output logic [OFFSET_BITS-1:0] load_offset,
	output logic [COUNT_BITS-1:0]  load_count
);

	logic                   lat_valid;
	logic                   lat_half;
	struct_id_t             lat_sel;
	struct_id_t             lat_struct;
	half_line_u             lat_data;
	logic [OFFSET_BITS-1:0] lat_offset;
	logic [COUNT_BITS-1:0]  lat_count;
	logic                   accept;

	// Control part, port 0 has priority over port 1
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			lat_valid <= 1'b0;
			lat_half  <= 1'b0;
			lat_sel   <= STRUCT_INVALID;
		end else if (enabled) begin
			lat_valid <= resp_0_valid | resp_1_valid;
			lat_half  <= ~resp_0_valid;
			lat_sel   <= struct_sel;
		end
	end

	// Response payload
	always_ff @(posedge clock) begin
		if (enabled) begin
			if (resp_0_valid) begin
				lat_data.raw <= resp_0_data.raw;
				lat_struct   <= resp_0_struct;
				lat_offset   <= resp_0_offset;
				lat_count    <= resp_0_count;
			end else if (resp_1_valid) begin
				lat_data.raw <= resp_1_data.raw;
				lat_struct   <= resp_1_struct;
				lat_offset   <= resp_1_offset;
				lat_count    <= resp_1_count;
			end
		end
	end

	// Match against the selection latched in the same cycle
	assign accept = lat_valid && (lat_struct == lat_sel) && (lat_sel != STRUCT_INVALID);

	assign wr_en       = accept;
	assign wr_half     = lat_half;
	assign wr_data     = lat_data;
	assign load        = accept;
	assign load_offset = lat_offset;
	assign load_count  = lat_count;

endmodule

/* logic/response_pkg.sv */
// Memory read response fields: structure id, start offset and word count
package response_pkg;

	// --------------------------------------------------
	// Structure id
	// --------------------------------------------------
	// Tags which data structure a response belongs to
	typedef logic [3:0] struct_id_t;

	// Reserved id, a response carrying it is never accepted
	localparam struct_id_t STRUCT_INVALID = 4'hF;

	// --------------------------------------------------
	// Stream descriptor widths
	// --------------------------------------------------
	// Start word index into the line
	localparam int OFFSET_BITS = 3;

	// Number of words to stream, 0 up to a full line of 8
	localparam int COUNT_BITS  = 4;

endpackage

/* logic/word_sequencer.sv */
// Word sequencer, walks the line from the offset for count words
module word_sequencer
	import line_format_pkg::*;
	import response_pkg::*;
#(
	parameter bit SWAP_BYTES = 1'b1
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  logic                       start_shift,
	input  logic                       load,
	input  logic [OFFSET_BITS-1:0]     load_offset,
	input  logic [COUNT_BITS-1:0]      load_count,
	input  logic [WORD_BITS-1:0]       rd_word,
	output logic [WORD_INDEX_BITS-1:0] rd_index,
	output logic [WORD_BITS-1:0]       word,
	output logic                       valid,
	output logic                       pending
);

	logic [COUNT_BITS-1:0] issued;
	logic [COUNT_BITS-1:0] limit;
	logic [COUNT_BITS-1:0] issued_next;
	logic                  issue;

	// One read per cycle while words remain and the consumer allows it
	assign issue       = enabled && start_shift && (issued < limit);
	assign issued_next = issued + COUNT_BITS'(issue);

	// --------------------------------------------------
	// Counters and pending flag
	// --------------------------------------------------
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_index <= '0;
			issued   <= '0;
			limit    <= '0;
			pending  <= 1'b0;
		end else if (!enabled) begin
			rd_index <= '0;
			issued   <= '0;
			limit    <= '0;
			pending  <= 1'b0;
		end else if (load) begin
			// A new accepted response restarts the stream
			rd_index <= load_offset;
			issued   <= '0;
			limit    <= load_count;
			pending  <= 1'b1;
		end else begin
			if (issue) begin
				rd_index <= rd_index + 1'b1;
			end
			issued  <= issued_next;
			// Drops after the last issue, or right away for count 0
			pending <= pending && (issued_next < limit);
		end
	end

	// --------------------------------------------------
	// Output valid
	// --------------------------------------------------
	// Lags issue by one cycle to match the registered read
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			valid <= 1'b0;
		end else begin
			valid <= issue;
		end
	end

	// Optional byte reversal of each word
	assign word = SWAP_BYTES ? swap_word_bytes(rd_word) : rd_word;

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the cache-line unpacking testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=cacheline_stream_tb
OBJ_DIR=obj_dir
LOG=sim.log

echo "Building $TOP"
if ! verilator --binary --timing --assert --top-module "$TOP" -Mdir "$OBJ_DIR" -f files.f; then
	echo "Verilator build failed"
	exit 1
fi

echo "Running $TOP"
"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi

echo "No failure reported in $LOG"
exit 0

/* sim/cacheline_stream_checker.sv */
// Concurrent assertions on the valid and pending levels of the unpacking path
module cacheline_stream_checker (
	input logic clock,
	input logic rstn,
	input logic enabled,
	input logic valid,
	input logic pending
);

	// --------------------------------------------------
	// Output levels
	// --------------------------------------------------
	// Every word belongs to a stream that was pending one cycle earlier
	valid_needs_pending: assert property (
		@(posedge clock) disable iff (!rstn)
		valid |-> $past(pending)
	) else $error("valid high without pending on the previous cycle");

	// Disabling the unit stops words after one edge
	valid_stops_when_disabled: assert property (
		@(posedge clock) disable iff (!rstn)
		!enabled |=> !valid
	) else $error("valid high in the cycle after enabled was low");

	// --------------------------------------------------
	// Reset
	// --------------------------------------------------
	pending_low_in_reset: assert property (
		@(posedge clock)
		!rstn |-> !pending
	) else $error("pending high while reset is asserted");

endmodule

// Attach to every instance of the top level
bind cacheline_stream_top cacheline_stream_checker i_checker (
	.clock   (clock),
	.rstn    (rstn),
	.enabled (enabled),
	.valid   (valid),
	.pending (pending)
);

/* sim/cacheline_stream_tb.sv */
// Testbench that runs directed tests on the cache-line unpacking path against a line model
module cacheline_stream_tb
	import line_format_pkg::*;
	import response_pkg::*;
();

	localparam int         CLOCK_PERIOD   = 20;
	localparam int         TIMEOUT_CYCLES = 2000;
	localparam struct_id_t ACTIVE_ID      = 4'h3;
	localparam struct_id_t OTHER_ID       = 4'h5;

	logic                   clock;
	logic                   rstn;
	logic                   enabled;
	logic                   start_shift;
	struct_id_t             struct_sel;
	logic                   resp_0_valid;
	half_line_u             resp_0_data;
	struct_id_t             resp_0_struct;
	logic [OFFSET_BITS-1:0] resp_0_offset;
	logic [COUNT_BITS-1:0]  resp_0_count;
	logic                   resp_1_valid;
	half_line_u             resp_1_data;
	struct_id_t             resp_1_struct;
	logic [OFFSET_BITS-1:0] resp_1_offset;
	logic [COUNT_BITS-1:0]  resp_1_count;
	logic [WORD_BITS-1:0]   word;
	logic                   valid;
	logic                   pending;

	// Reference copy of the line and the word queues
	logic [WORD_BITS-1:0] line_model [WORDS_PER_LINE];
	logic [WORD_BITS-1:0] seen_q [$];
	logic [WORD_BITS-1:0] expect_q [$];
	int                   error_count = 0;
	int                   test_count  = 0;
	int                   cycle_count = 0;

	cacheline_stream_top #(
		.SWAP_BYTES (1'b1)
	) i_dut (
		.clock (clock), .rstn (rstn), .enabled (enabled), .start_shift (start_shift),
		.struct_sel (struct_sel),
		.resp_0_valid (resp_0_valid), .resp_0_data (resp_0_data),
		.resp_0_struct (resp_0_struct), .resp_0_offset (resp_0_offset),
		.resp_0_count (resp_0_count),
		.resp_1_valid (resp_1_valid), .resp_1_data (resp_1_data),
		.resp_1_struct (resp_1_struct), .resp_1_offset (resp_1_offset),
		.resp_1_count (resp_1_count),
		.word (word), .valid (valid), .pending (pending)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped by timeout after %0d cycles", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// Collect every output word at the falling edge
	always @(negedge clock) begin
		if (rstn && valid) begin
			seen_q.push_back(word);
		end
	end

	// --------------------------------------------------
	// Model and helpers
	// --------------------------------------------------
	function automatic logic [WORD_BITS-1:0] reverse_bytes(input logic [WORD_BITS-1:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	task automatic random_half(output logic [HALF_BITS-1:0] data);
		for (int k = 0; k < WORDS_PER_HALF; k++) begin
			data[WORD_BITS*k +: WORD_BITS] = $urandom;
		end
	endtask

	// Half 0 holds words 0 to 3 and half 1 holds words 4 to 7
	task automatic store_half(input int half, input logic [HALF_BITS-1:0] data);
		for (int k = 0; k < WORDS_PER_HALF; k++) begin
			line_model[half*WORDS_PER_HALF + k] = data[WORD_BITS*k +: WORD_BITS];
		end
	endtask

	task automatic predict_stream(input logic [OFFSET_BITS-1:0] offset, input int count);
		expect_q.delete();
		for (int i = 0; i < count; i++) begin
			expect_q.push_back(reverse_bytes(line_model[(offset + i) % WORDS_PER_LINE]));
		end
	endtask

	task automatic check_level(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %b actual %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_stream(input string what);
		int n;
		n = (seen_q.size() < expect_q.size()) ? seen_q.size() : expect_q.size();
		if (seen_q.size() != expect_q.size()) begin
			$display("%s: expected %0d words but saw %0d", what, expect_q.size(), seen_q.size());
			error_count++;
		end
		for (int i = 0; i < n; i++) begin
			if (seen_q[i] !== expect_q[i]) begin
				$display("** Error at %0t: word expected %h actual %h", $time, expect_q[i],
					seen_q[i]);
				error_count++;
			end
		end
	endtask

	// Holds the response for exactly one sampling edge
	task automatic send_response(input int port, input struct_id_t id,
		input logic [HALF_BITS-1:0] data, input logic [OFFSET_BITS-1:0] offset,
		input logic [COUNT_BITS-1:0] count);
		@(posedge clock);
		#2;
		if (port == 0) begin
			resp_0_valid    = 1'b1;
			resp_0_data.raw = data;
			resp_0_struct   = id;
			resp_0_offset   = offset;
			resp_0_count    = count;
		end else begin
			resp_1_valid    = 1'b1;
			resp_1_data.raw = data;
			resp_1_struct   = id;
			resp_1_offset   = offset;
			resp_1_count    = count;
		end
		@(posedge clock);
		#2;
		resp_0_valid = 1'b0;
		resp_1_valid = 1'b0;
	endtask

	task automatic wait_stream_done(input bit toggle);
		int n;
		n = 0;
		while (pending !== 1'b1 && n < 4) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (pending !== 1'b1) begin
			$display("At %0t pending never rose after an accepted response", $time);
			error_count++;
		end else begin
			n = 0;
			while (pending === 1'b1 && n < 100) begin
				if (toggle) begin
					start_shift = 1'($urandom_range(0, 1));
				end
				@(posedge clock);
				#2;
				n++;
			end
			start_shift = 1'b1;
			if (pending !== 1'b0) begin
				$display("At %0t stream did not finish within 100 cycles", $time);
				error_count++;
			end
		end
		// The last word reaches the collector after pending falls
		@(posedge clock);
		#2;
		@(posedge clock);
		#2;
	endtask

	task automatic run_stream(input int port, input logic [OFFSET_BITS-1:0] offset,
		input logic [COUNT_BITS-1:0] count, input bit toggle, input string what);
		logic [HALF_BITS-1:0] data;
		random_half(data);
		store_half(port, data);
		predict_stream(offset, int'(count));
		seen_q.delete();
		send_response(port, struct_sel, data, offset, count);
		wait_stream_done(toggle);
		compare_stream(what);
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		test_count++;
		$display("%s finished, %0d errors", name, error_count - errors_at_start);
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic half0_stream_test();
		int start;
		start = error_count;
		run_stream(0, 3'd0, 4'd4, 1'b0, "test 1");
		check_level("pending", 1'b0, pending);
		report_test("test 1 port 0 offset 0 count 4", start);
	endtask

	task automatic wrap_stream_test();
		int start;
		start = error_count;
		run_stream(1, 3'd5, 4'd6, 1'b0, "test 2");
		report_test("test 2 port 1 wrap from offset 5", start);
	endtask

	task automatic mismatch_id_test();
		int                   start;
		logic [HALF_BITS-1:0] data;
		start = error_count;
		random_half(data);
		seen_q.delete();
		send_response(0, OTHER_ID, data, 3'd0, 4'd8);
		repeat (6) begin
			check_level("valid", 1'b0, valid);
			check_level("pending", 1'b0, pending);
			@(posedge clock);
			#2;
		end
		// Rewrite half 1 unchanged, so the full line shows whether half 0 survived
		for (int k = 0; k < WORDS_PER_HALF; k++) begin
			data[WORD_BITS*k +: WORD_BITS] = line_model[WORDS_PER_HALF + k];
		end
		predict_stream(3'd0, 8);
		seen_q.delete();
		send_response(1, struct_sel, data, 3'd0, 4'd8);
		wait_stream_done(1'b0);
		compare_stream("test 3");
		report_test("test 3 mismatched id rejected", start);
	endtask

	task automatic stall_stream_test();
		int start;
		start = error_count;
		run_stream(0, 3'd3, 4'd8, 1'b1, "test 4");
		report_test("test 4 start_shift toggling", start);
	endtask

	task automatic disable_mid_stream_test();
		int                   start;
		logic [HALF_BITS-1:0] data;
		start = error_count;
		random_half(data);
		store_half(0, data);
		predict_stream(3'd2, 8);
		seen_q.delete();
		send_response(0, struct_sel, data, 3'd2, 4'd8);
		@(posedge clock);
		#2;
		check_level("pending", 1'b1, pending);
		// Three reads issue before the drop
		repeat (3) @(posedge clock);
		#2;
		enabled = 1'b0;
		@(posedge clock);
		#2;
		check_level("pending", 1'b0, pending);
		check_level("valid", 1'b0, valid);
		repeat (4) @(posedge clock);
		#2;
		while (expect_q.size() > 3) begin
			void'(expect_q.pop_back());
		end
		compare_stream("test 5");
		enabled = 1'b1;
		repeat (2) @(posedge clock);
		#2;
		check_level("pending", 1'b0, pending);
		report_test("test 5 enabled dropped mid-stream", start);
	endtask

	task automatic random_response_test();
		int start;
		start = error_count;
		for (int i = 0; i < 20; i++) begin
			run_stream($urandom_range(0, 1), OFFSET_BITS'($urandom_range(0, 7)),
				COUNT_BITS'($urandom_range(0, 8)), 1'b0, $sformatf("test 6 response %0d", i));
		end
		report_test("test 6 twenty random responses", start);
	endtask

	initial begin
		void'($urandom(32'h60af));
		rstn          = 1'b0;
		enabled       = 1'b0;
		start_shift   = 1'b0;
		struct_sel    = ACTIVE_ID;
		resp_0_valid  = 1'b0;
		resp_0_data   = '0;
		resp_0_struct = STRUCT_INVALID;
		resp_0_offset = '0;
		resp_0_count  = '0;
		resp_1_valid  = 1'b0;
		resp_1_data   = '0;
		resp_1_struct = STRUCT_INVALID;
		resp_1_offset = '0;
		resp_1_count  = '0;
		repeat (10) @(posedge clock);
		#2;
		rstn        = 1'b1;
		enabled     = 1'b1;
		start_shift = 1'b1;
		repeat (2) @(posedge clock);
		#2;
		half0_stream_test();
		wrap_stream_test();
		mismatch_id_test();
		stall_stream_test();
		disable_mid_stream_test();
		random_response_test();
		$display("Tests run %0d, errors %0d, cycles %0d", test_count, error_count, cycle_count);
		if (error_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule
